//--- include/issue_settings.svh
/* Issue stage widths and depths */

`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Data path width
`define ISSUE_XLEN 32

// Physical register tag width
`define ISSUE_PREG_BITS 6

// ROB tag, carried through untouched
`define ISSUE_ROB_BITS 5

// Entries per reservation station
`define ISSUE_RS_DEPTH 4

// Multiplier latency in cycles from issue to result
`define ISSUE_MUL_STAGES 2

`endif

//--- source/issue_pkg.sv
/* Issue stage types */

`include "issue_settings.svh"

package issue_pkg;

    typedef logic [`ISSUE_XLEN-1:0]      word_t;
    typedef logic [`ISSUE_PREG_BITS-1:0] preg_t;
    typedef logic [`ISSUE_ROB_BITS-1:0]  rob_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

    typedef enum logic {
        FU_ALU,
        FU_MUL
    } fu_sel_e;

    // Source operand, value is only meaningful once received
    typedef struct packed {
        logic  received;
        preg_t tag;
        word_t value;
    } operand_t;

    typedef struct packed {
        fu_sel_e    fu;
        logic [3:0] op;
        rob_t       rob;
        preg_t      dst;
        operand_t   src1;
        operand_t   src2;
    } uop_t;

    typedef struct packed {
        alu_op_e op;
        rob_t    rob;
        preg_t   dst;
    } alu_payload_t;

    typedef struct packed {
        logic  signed_hi;
        rob_t  rob;
        preg_t dst;
    } mul_payload_t;

    typedef struct packed {
        word_t op1;
        word_t op2;
    } issue_pkt_t;

    typedef struct packed {
        preg_t dst;
        rob_t  rob;
        word_t value;
    } result_t;

endpackage

//--- source/slot_picker.sv
/* Lowest index slot picker */

module slot_picker #(
    parameter int WIDTH = 4,
    parameter int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic [WIDTH-1:0] slots,
    output logic [IDX_W-1:0] index,
    output logic             none
);

    // Scan downward so the lowest set bit wins
    always_comb begin
        index = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (slots[i]) begin
                index = IDX_W'(i);
            end
        end
    end

    assign none = ~|slots;

endmodule

//--- source/reservation_station.sv
/* Reservation station with tag wakeup */

module reservation_station #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = issue_pkg::alu_payload_t
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         alloc_valid,
    output logic                         alloc_ready,
    input  issue_pkg::operand_t [1:0]    alloc_ops,
    input  payload_t                     alloc_payload,

    input  logic                         bcast_valid,
    input  issue_pkg::result_t           bcast,

    output logic                         issue_valid,
    input  logic                         issue_ready,
    output issue_pkg::issue_pkt_t        issue_pkt,
    output payload_t                     issue_payload
);

    import issue_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0] busy_q;
    operand_t [1:0]   ops_q [DEPTH];
    payload_t         pay_q [DEPTH];

    logic [DEPTH-1:0] ready_mask;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] ready_idx;
    logic             none_free;
    logic             none_ready;

    // Capture the broadcast value when it carries the awaited tag
    function automatic operand_t snoop(operand_t op, logic bv, result_t b);
        operand_t res;
        res = op;
        if (bv && !op.received && (op.tag == b.dst)) begin
            res.received = 1'b1;
            res.value    = b.value;
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ready_mask[i] = busy_q[i] & ops_q[i][0].received & ops_q[i][1].received;
        end
    end

    slot_picker #(
        .WIDTH (DEPTH),
        .IDX_W (IDX_W)
    ) i_free_picker (
        .slots (~busy_q),
        .index (free_idx),
        .none  (none_free)
    );

    slot_picker #(
        .WIDTH (DEPTH),
        .IDX_W (IDX_W)
    ) i_ready_picker (
        .slots (ready_mask),
        .index (ready_idx),
        .none  (none_ready)
    );

    assign alloc_ready   = ~none_free;
    assign issue_valid   = ~none_ready;
    assign issue_pkt.op1 = ops_q[ready_idx][0].value;
    assign issue_pkt.op2 = ops_q[ready_idx][1].value;
    assign issue_payload = pay_q[ready_idx];

    // Occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            if (issue_valid && issue_ready) begin
                busy_q[ready_idx] <= 1'b0;
            end
            if (alloc_valid && alloc_ready) begin
                busy_q[free_idx] <= 1'b1;
            end
        end
    end

    // Operand wakeup and allocation
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (busy_q[i]) begin
                ops_q[i][0] <= snoop(ops_q[i][0], bcast_valid, bcast);
                ops_q[i][1] <= snoop(ops_q[i][1], bcast_valid, bcast);
            end
        end
        // A new uop may see its source tag broadcast this very cycle
        if (alloc_valid && alloc_ready) begin
            ops_q[free_idx][0] <= snoop(alloc_ops[0], bcast_valid, bcast);
            ops_q[free_idx][1] <= snoop(alloc_ops[1], bcast_valid, bcast);
            pay_q[free_idx]    <= alloc_payload;
        end
    end

endmodule

//--- source/alu_unit.sv
/* Single cycle integer ALU */

module alu_unit (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      issue_valid,
    output logic                      issue_ready,
    input  issue_pkg::issue_pkt_t     issue_pkt,
    input  issue_pkg::alu_payload_t   issue_payload,

    output logic                      fu_valid,
    output issue_pkg::result_t        fu_result,
    input  logic                      grant
);

    import issue_pkg::*;

    localparam int W = $bits(word_t);

    logic    res_valid_q;
    result_t res_q;
    word_t   alu_val;

    always_comb begin
        case (issue_payload.op)
            ALU_ADD: alu_val = issue_pkt.op1 + issue_pkt.op2;
            ALU_SUB: alu_val = issue_pkt.op1 - issue_pkt.op2;
            ALU_AND: alu_val = issue_pkt.op1 & issue_pkt.op2;
            ALU_OR:  alu_val = issue_pkt.op1 | issue_pkt.op2;
            ALU_XOR: alu_val = issue_pkt.op1 ^ issue_pkt.op2;
            ALU_SLL: alu_val = issue_pkt.op1 << issue_pkt.op2[4:0];
            ALU_SRL: alu_val = issue_pkt.op1 >> issue_pkt.op2[4:0];
            ALU_SLT: alu_val = {{(W-1){1'b0}}, $signed(issue_pkt.op1) < $signed(issue_pkt.op2)};
            default: alu_val = '0;
        endcase
    end

    // Accept when empty or when the held result leaves this cycle
    assign issue_ready = ~res_valid_q | grant;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid_q <= 1'b0;
        end else if (issue_valid && issue_ready) begin
            res_valid_q <= 1'b1;
        end else if (grant) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            res_q.dst   <= issue_payload.dst;
            res_q.rob   <= issue_payload.rob;
            res_q.value <= alu_val;
        end
    end

    assign fu_valid  = res_valid_q;
    assign fu_result = res_q;

endmodule

//--- source/mul_unit.sv
/* Two stage pipelined multiplier */

module mul_unit (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      issue_valid,
    output logic                      issue_ready,
    input  issue_pkg::issue_pkt_t     issue_pkt,
    input  issue_pkg::mul_payload_t   issue_payload,

    output logic                      fu_valid,
    output issue_pkg::result_t        fu_result
);

    import issue_pkg::*;

    localparam int W = $bits(word_t);

    logic         ready_q;
    logic         s1_valid_q;
    word_t        s1_a_q;
    word_t        s1_b_q;
    mul_payload_t s1_pay_q;
    logic         s2_valid_q;
    result_t      s2_res_q;
    logic [2*W-1:0] prod;

    // Never stalls, so ready only waits for reset to lift
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q    <= 1'b0;
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            ready_q    <= 1'b1;
            s1_valid_q <= issue_valid & issue_ready;
            s2_valid_q <= s1_valid_q;
        end
    end

    assign issue_ready = ready_q;

    always_ff @(posedge clk) begin
        s1_a_q   <= issue_pkt.op1;
        s1_b_q   <= issue_pkt.op2;
        s1_pay_q <= issue_payload;
    end

    always_comb begin
        if (s1_pay_q.signed_hi) begin
            prod = $signed(s1_a_q) * $signed(s1_b_q);
        end else begin
            prod = s1_a_q * s1_b_q;
        end
    end

    always_ff @(posedge clk) begin
        s2_res_q.dst   <= s1_pay_q.dst;
        s2_res_q.rob   <= s1_pay_q.rob;
        s2_res_q.value <= s1_pay_q.signed_hi ? prod[2*W-1:W] : prod[W-1:0];
    end

    assign fu_valid  = s2_valid_q;
    assign fu_result = s2_res_q;

endmodule

//--- source/result_bus.sv
/* Result broadcast arbiter */

module result_bus (
    input  logic                 mul_valid,
    input  issue_pkg::result_t   mul_result,

    input  logic                 alu_valid,
    input  issue_pkg::result_t   alu_result,
    output logic                 alu_grant,

    input  logic                 ext_valid,
    input  issue_pkg::result_t   ext_result,
    output logic                 ext_ready,

    output logic                 bcast_valid,
    output issue_pkg::result_t   bcast
);

    // One hot, bit 2 is mul, bit 1 alu, bit 0 external
    logic [2:0] grant;

    assign grant[2] = mul_valid;
    assign grant[1] = alu_valid & ~mul_valid;
    assign grant[0] = ext_valid & ~mul_valid & ~alu_valid;

    assign alu_grant   = grant[1];
    assign ext_ready   = grant[0];
    assign bcast_valid = |grant;

    always_comb begin
        if (grant[2]) begin
            bcast = mul_result;
        end else if (grant[1]) begin
            bcast = alu_result;
        end else begin
            bcast = ext_result;
        end
    end

endmodule

//--- source/issue_core.sv
/* Issue stage top level */

`include "issue_settings.svh"

module issue_core (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 dispatch_valid,
    output logic                 dispatch_ready,
    input  issue_pkg::uop_t      dispatch_uop,

    input  logic                 ext_valid,
    output logic                 ext_ready,
    input  issue_pkg::result_t   ext_result,

    output logic                 bcast_valid,
    output issue_pkg::result_t   bcast
);

    import issue_pkg::*;

    logic           alu_alloc_valid;
    logic           alu_alloc_ready;
    logic           mul_alloc_valid;
    logic           mul_alloc_ready;
    operand_t [1:0] disp_ops;
    alu_payload_t   disp_alu_pay;
    mul_payload_t   disp_mul_pay;

    logic           alu_issue_valid;
    logic           alu_issue_ready;
    issue_pkt_t     alu_pkt;
    alu_payload_t   alu_iss_pay;
    logic           mul_issue_valid;
    logic           mul_issue_ready;
    issue_pkt_t     mul_pkt;
    mul_payload_t   mul_iss_pay;

    logic           alu_fu_valid;
    result_t        alu_fu_result;
    logic           alu_grant;
    logic           mul_fu_valid;
    result_t        mul_fu_result;

    // Steer by unit field
    assign alu_alloc_valid = dispatch_valid & (dispatch_uop.fu == FU_ALU);
    assign mul_alloc_valid = dispatch_valid & (dispatch_uop.fu == FU_MUL);
    assign dispatch_ready  = (dispatch_uop.fu == FU_MUL) ? mul_alloc_ready : alu_alloc_ready;

    assign disp_ops[0] = dispatch_uop.src1;
    assign disp_ops[1] = dispatch_uop.src2;

    assign disp_alu_pay.op  = alu_op_e'(dispatch_uop.op[2:0]);
    assign disp_alu_pay.rob = dispatch_uop.rob;
    assign disp_alu_pay.dst = dispatch_uop.dst;

    // Mul op bit 0 selects the signed high word
    assign disp_mul_pay.signed_hi = dispatch_uop.op[0];
    assign disp_mul_pay.rob       = dispatch_uop.rob;
    assign disp_mul_pay.dst       = dispatch_uop.dst;

    reservation_station #(
        .DEPTH     (`ISSUE_RS_DEPTH),
        .payload_t (alu_payload_t)
    ) i_alu_rs (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_valid   (alu_alloc_valid),
        .alloc_ready   (alu_alloc_ready),
        .alloc_ops     (disp_ops),
        .alloc_payload (disp_alu_pay),
        .bcast_valid   (bcast_valid),
        .bcast         (bcast),
        .issue_valid   (alu_issue_valid),
        .issue_ready   (alu_issue_ready),
        .issue_pkt     (alu_pkt),
        .issue_payload (alu_iss_pay)
    );

    reservation_station #(
        .DEPTH     (`ISSUE_RS_DEPTH),
        .payload_t (mul_payload_t)
    ) i_mul_rs (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_valid   (mul_alloc_valid),
        .alloc_ready   (mul_alloc_ready),
        .alloc_ops     (disp_ops),
        .alloc_payload (disp_mul_pay),
        .bcast_valid   (bcast_valid),
        .bcast         (bcast),
        .issue_valid   (mul_issue_valid),
        .issue_ready   (mul_issue_ready),
        .issue_pkt     (mul_pkt),
        .issue_payload (mul_iss_pay)
    );

    alu_unit i_alu (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (alu_issue_valid),
        .issue_ready   (alu_issue_ready),
        .issue_pkt     (alu_pkt),
        .issue_payload (alu_iss_pay),
        .fu_valid      (alu_fu_valid),
        .fu_result     (alu_fu_result),
        .grant         (alu_grant)
    );

    mul_unit i_mul (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (mul_issue_valid),
        .issue_ready   (mul_issue_ready),
        .issue_pkt     (mul_pkt),
        .issue_payload (mul_iss_pay),
        .fu_valid      (mul_fu_valid),
        .fu_result     (mul_fu_result)
    );

    result_bus i_result_bus (
        .mul_valid   (mul_fu_valid),
        .mul_result  (mul_fu_result),
        .alu_valid   (alu_fu_valid),
        .alu_result  (alu_fu_result),
        .alu_grant   (alu_grant),
        .ext_valid   (ext_valid),
        .ext_result  (ext_result),
        .ext_ready   (ext_ready),
        .bcast_valid (bcast_valid),
        .bcast       (bcast)
    );

endmodule

//--- bench/issue_core_chk.sv
/* Issue stage handshake assertions */

module issue_core_chk (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 dispatch_valid,
    input logic                 dispatch_ready,
    input issue_pkg::uop_t      dispatch_uop,
    input logic                 ext_valid,
    input logic                 ext_ready,
    input issue_pkg::result_t   ext_result,
    input logic                 bcast_valid,
    input logic                 alu_fu_valid,
    input issue_pkg::result_t   alu_fu_result,
    input logic                 alu_grant,
    input logic                 mul_fu_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Set once the first reset edge has passed
    logic reset_seen_q = 1'b0;

    // Assertion failures so far
    int fail_count = 0;

    always @(posedge clk) begin
        if (!rst_n) begin
            reset_seen_q <= 1'b1;
        end
    end

    dispatch_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch_valid && !dispatch_ready |=> dispatch_valid && $stable(dispatch_uop))
        else begin
            $error("dispatch request changed while stalled");
            fail_count++;
        end

    ext_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ext_valid && !ext_ready |=> ext_valid && $stable(ext_result))
        else begin
            $error("external result changed while stalled");
            fail_count++;
        end

    alu_hold: assert property (@(posedge clk) disable iff (!rst_n)
        alu_fu_valid && !alu_grant |=> alu_fu_valid && $stable(alu_fu_result))
        else begin
            $error("ALU result changed while not granted");
            fail_count++;
        end

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({mul_fu_valid, alu_grant, ext_ready}))
        else begin
            $error("more than one result source granted");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        reset_seen_q && !rst_n |-> !bcast_valid)
        else begin
            $error("broadcast active during reset");
            fail_count++;
        end

endmodule

bind issue_core issue_core_chk i_chk (.*);

//--- bench/issue_scoreboard.sv
/* Broadcast scoreboard */

`include "issue_settings.svh"

module issue_scoreboard (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 bcast_valid,
    input issue_pkg::result_t   bcast,
    input logic                 dispatch_valid,
    input logic                 dispatch_ready,
    input logic                 ext_ready,
    input logic                 mul_valid,
    input logic                 alu_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    import issue_pkg::*;

    localparam int NTAGS = 1 << `ISSUE_PREG_BITS;

    logic  pending [NTAGS];
    logic  seen    [NTAGS];
    word_t exp_val [NTAGS];
    rob_t  exp_rob [NTAGS];
    int    pending_cnt  = 0;
    int    error_count  = 0;
    int    test_count   = 0;
    int    failed_count = 0;
    int    error_mark   = 0;
    int    stall_cnt    = 0;

    initial begin
        for (int i = 0; i < NTAGS; i++) begin
            pending[i] = 1'b0;
            seen[i]    = 1'b0;
        end
    end

    task automatic expect_result(input preg_t dst, input rob_t rob, input word_t value);
        pending[dst] = 1'b1;
        exp_val[dst] = value;
        exp_rob[dst] = rob;
        pending_cnt++;
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        error_count++;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (dispatch_valid && !dispatch_ready) begin
                stall_cnt++;
            end
            if (ext_ready && (mul_valid || alu_valid)) begin
                note_failure("external port accepted while a higher source was valid");
            end
            if (bcast_valid) begin
                if (!pending[bcast.dst]) begin
                    $display("broadcast of tag %0d that was not expected", bcast.dst);
                    error_count++;
                end else begin
                    if (bcast.value !== exp_val[bcast.dst]) begin
                        $display("error bcast.value tag %0d: got %h expected %h",
                                 bcast.dst, bcast.value, exp_val[bcast.dst]);
                        error_count++;
                    end
                    if (bcast.rob !== exp_rob[bcast.dst]) begin
                        $display("error bcast.rob tag %0d: got %h expected %h",
                                 bcast.dst, bcast.rob, exp_rob[bcast.dst]);
                        error_count++;
                    end
                    pending[bcast.dst] = 1'b0;
                    pending_cnt--;
                end
                seen[bcast.dst] = 1'b1;
            end
        end
    end

    task automatic start_test();
        error_mark = error_count;
        stall_cnt  = 0;
    endtask

    task automatic check_idle();
        if (bcast_valid !== 1'b0) begin
            $display("error bcast_valid: got %h expected 0", bcast_valid);
            error_count++;
        end
        if (dispatch_ready !== 1'b1) begin
            $display("error dispatch_ready: got %h expected 1", dispatch_ready);
            error_count++;
        end
    endtask

    task automatic require_stall();
        if (stall_cnt == 0) begin
            note_failure("dispatch_ready never dropped while the station was full");
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == error_mark) begin
            $display("test %s: pass", name);
        end else begin
            failed_count++;
            $display("test %s: fail with %0d errors", name, error_count - error_mark);
        end
    endtask

endmodule

//--- include/issue_bench_settings.svh
/* Testbench limits */

`ifndef ISSUE_BENCH_SETTINGS_SVH
`define ISSUE_BENCH_SETTINGS_SVH

// Cycles any single wait may take
`define ISSUE_TB_TIMEOUT 200

`endif

//--- bench/issue_core_tb.sv
/* Issue stage testbench */

`include "issue_settings.svh"
`include "issue_bench_settings.svh"

module issue_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import issue_pkg::*;

    localparam int NTAGS = 1 << `ISSUE_PREG_BITS;
    localparam int TIMEOUT = `ISSUE_TB_TIMEOUT;

    typedef struct packed {
        logic [2:0] test;
        logic       is_ext;
        logic       fu;
        logic [3:0] op;
        preg_t      dst;
        logic       s1_tag;
        preg_t      s1;
        logic       s2_tag;
        preg_t      s2;
        logic       rnd_gap;
        logic [3:0] gap;
        logic [3:0] delay;
    } row_t;

    logic    clk;
    logic    rst_n;
    logic    dispatch_valid;
    logic    dispatch_ready;
    uop_t    dispatch_uop;
    logic    ext_valid;
    logic    ext_ready;
    result_t ext_result;
    logic    bcast_valid;
    result_t bcast;

    row_t        tbl[$];
    word_t       vals [NTAGS];
    logic [31:0] lfsr;
    string       names [5] = '{"alu_ops", "mul_ops", "wakeup", "capacity", "arbitration"};

    issue_core i_issue_core (.*);

    issue_scoreboard i_sb (
        .clk            (clk),
        .rst_n          (rst_n),
        .bcast_valid    (bcast_valid),
        .bcast          (bcast),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .ext_ready      (ext_ready),
        .mul_valid      (i_issue_core.mul_fu_valid),
        .alu_valid      (i_issue_core.alu_fu_valid)
    );

    always #5 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // Reference result from the opcode rules
    function automatic word_t model(input logic fu, input logic [3:0] op, input word_t a,
                                    input word_t b);
        if (fu) begin
            return a * b;
        end
        case (alu_op_e'(op[2:0]))
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // Negative source means an immediate, negative gap means a random gap
    function automatic row_t disp_row(input int t, input logic fu, input int op, input int dst,
                                      input int s1, input int s2, input int gap);
        row_t r;
        r         = '0;
        r.test    = 3'(t);
        r.fu      = fu;
        r.op      = 4'(op);
        r.dst     = preg_t'(dst);
        r.s1_tag  = (s1 >= 0);
        r.s1      = (s1 >= 0) ? preg_t'(s1) : '0;
        r.s2_tag  = (s2 >= 0);
        r.s2      = (s2 >= 0) ? preg_t'(s2) : '0;
        r.rnd_gap = (gap < 0);
        r.gap     = (gap < 0) ? 4'd0 : 4'(gap);
        return r;
    endfunction

    function automatic row_t ext_row(input int t, input int dst, input int delay);
        row_t r;
        r        = '0;
        r.test   = 3'(t);
        r.is_ext = 1'b1;
        r.dst    = preg_t'(dst);
        r.delay  = 4'(delay);
        return r;
    endfunction

    task automatic load_table();
        for (int op = 0; op < 8; op++) begin
            tbl.push_back(disp_row(0, 1'b0, op, 1 + op, -1, -1, -1));
        end
        for (int i = 0; i < 4; i++) begin
            tbl.push_back(disp_row(1, 1'b1, 0, 9 + i, -1, -1, 0));
        end
        // Tag 17 is dispatched in the cycle that broadcasts tag 16
        tbl.push_back(disp_row(2, 1'b0, ALU_ADD, 16, -1, -1, 0));
        tbl.push_back(disp_row(2, 1'b0, ALU_XOR, 17, 16, -1, 1));
        tbl.push_back(disp_row(2, 1'b0, ALU_OR, 13, -1, -1, 0));
        tbl.push_back(disp_row(2, 1'b1, 0, 14, 13, -1, 0));
        tbl.push_back(disp_row(2, 1'b0, ALU_SUB, 15, 14, 13, 0));
        tbl.push_back(ext_row(3, 20, 12));
        for (int i = 1; i < 4; i++) begin
            tbl.push_back(ext_row(3, 20 + i, 1));
        end
        for (int i = 0; i < 4; i++) begin
            tbl.push_back(disp_row(3, 1'b0, ALU_ADD, 24 + i, 20 + i, -1, 0));
        end
        tbl.push_back(disp_row(3, 1'b0, ALU_SLT, 28, -1, -1, 0));
        tbl.push_back(disp_row(4, 1'b1, 0, 30, -1, -1, 0));
        tbl.push_back(disp_row(4, 1'b0, ALU_SLL, 32, -1, -1, 0));
        tbl.push_back(disp_row(4, 1'b1, 0, 31, -1, -1, 0));
        tbl.push_back(disp_row(4, 1'b0, ALU_SRL, 33, -1, -1, 0));
        tbl.push_back(ext_row(4, 34, 2));
        tbl.push_back(ext_row(4, 35, 0));
    endtask

    task automatic make_operand(input logic is_tag, input preg_t tag, output operand_t op,
                                output word_t v);
        if (is_tag) begin
            v  = vals[tag];
            op = i_sb.seen[tag] ? {1'b1, tag, v} : {1'b0, tag, 32'd0};
        end else begin
            draw(32, v);
            op = {1'b1, preg_t'(0), v};
        end
    endtask

    task automatic send_uop(input row_t r);
        uop_t        u;
        word_t       a;
        word_t       b;
        logic [31:0] g;
        int          n;
        logic        ok;
        if (r.rnd_gap) begin
            draw(2, g);
        end else begin
            g = 32'(r.gap);
        end
        repeat (g) begin
            @(negedge clk);
            dispatch_valid = 1'b0;
        end
        @(negedge clk);
        make_operand(r.s1_tag, r.s1, u.src1, a);
        make_operand(r.s2_tag, r.s2, u.src2, b);
        u.fu  = fu_sel_e'(r.fu);
        u.op  = r.op;
        u.rob = rob_t'(r.dst);
        u.dst = r.dst;
        vals[r.dst] = model(r.fu, r.op, a, b);
        i_sb.expect_result(r.dst, u.rob, vals[r.dst]);
        dispatch_uop   = u;
        dispatch_valid = 1'b1;
        n  = 0;
        ok = 1'b0;
        while (!ok) begin
            #1;
            ok = dispatch_ready;
            @(posedge clk);
            if (!ok) begin
                n++;
                if (n > TIMEOUT) begin
                    i_sb.note_failure($sformatf("dispatch of tag %0d was never accepted", r.dst));
                    break;
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic send_ext(input row_t r);
        int   n;
        logic ok;
        repeat (r.delay) @(negedge clk);
        @(negedge clk);
        ext_result = {r.dst, rob_t'(r.dst), vals[r.dst]};
        ext_valid  = 1'b1;
        n  = 0;
        ok = 1'b0;
        while (!ok) begin
            #1;
            ok = ext_ready;
            @(posedge clk);
            if (!ok) begin
                n++;
                if (n > TIMEOUT) begin
                    i_sb.note_failure($sformatf("external tag %0d was never accepted", r.dst));
                    break;
                end
                @(negedge clk);
            end
        end
        @(negedge clk);
        ext_valid = 1'b0;
    endtask

    task automatic run_test(input int t);
        logic [31:0] v;
        int          n;
        i_sb.start_test();
        // External values are known before any consumer is dispatched
        foreach (tbl[i]) begin
            if (tbl[i].test == t && tbl[i].is_ext) begin
                draw(32, v);
                vals[tbl[i].dst] = v;
                i_sb.expect_result(tbl[i].dst, rob_t'(tbl[i].dst), v);
            end
        end
        fork
            begin
                foreach (tbl[i]) begin
                    if (tbl[i].test == t && !tbl[i].is_ext) begin
                        send_uop(tbl[i]);
                    end
                end
                @(negedge clk);
                dispatch_valid = 1'b0;
            end
            begin
                foreach (tbl[i]) begin
                    if (tbl[i].test == t && tbl[i].is_ext) begin
                        send_ext(tbl[i]);
                    end
                end
            end
        join
        n = 0;
        while (i_sb.pending_cnt != 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                i_sb.note_failure("results still missing after the drain wait");
                break;
            end
        end
        // Room for a duplicate broadcast to show up
        repeat (4) @(negedge clk);
        if (t == 3) begin
            i_sb.require_stall();
        end
        i_sb.end_test(names[t]);
    endtask

    initial begin
        int total_errors;
        clk            = 1'b0;
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        ext_valid      = 1'b0;
        ext_result     = '0;
        lfsr           = 32'h65b7118b;
        load_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        i_sb.start_test();
        @(negedge clk);
        i_sb.check_idle();
        i_sb.end_test("reset");
        for (int t = 0; t < 5; t++) begin
            run_test(t);
        end
        total_errors = i_sb.error_count + i_issue_core.i_chk.fail_count;
        $display("tests %0d, failed %0d, errors %0d",
                 i_sb.test_count, i_sb.failed_count, total_errors);
        if (total_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
source/issue_pkg.sv
source/slot_picker.sv
source/reservation_station.sv
source/alu_unit.sv
source/mul_unit.sv
source/result_bus.sv
source/issue_core.sv
bench/issue_core_chk.sv
bench/issue_scoreboard.sv
bench/issue_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= issue_core_tb
FILELIST  ?= compile.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(shell sed -n '/\.sv$$/p' $(FILELIST)) $(wildcard include/*.svh)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
